//--- Makefile
TOP = tb_nes_debugger

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

//--- sim.f
verilog/nes_debugger_pkg.sv
verilog/debugger_if.sv
verilog/memory_bank.sv
verilog/spi_peripheral.sv
verilog/debugger_cmd.sv
verilog/debugger_values.sv
verilog/debug_mem_hub.sv
verilog/nes_debugger_top.sv
testbench/nes_debugger_asserts.sv
testbench/tb_nes_debugger.sv

//--- testbench/nes_debugger_asserts.sv
// ##############################
// protocol checks bound into the memory hub
// ##############################

module nes_debugger_asserts (
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_en,
  input logic        i_rw,
  input logic [15:0] i_addr,
  input logic        i_done,
  input logic        i_prg_en,
  input logic        i_ram_en
);

  // done only while a request is pending
  a_done_with_en: assert property (@(posedge i_clk) disable iff (i_rst)
    i_done |-> i_en)
    else $error("done without a pending debugger request");

  // nes buses idle for at least one cycle after each access
  a_prg_gap: assert property (@(posedge i_clk) disable iff (i_rst)
    i_prg_en |=> !i_prg_en)
    else $error("prg enable held for two cycles");

  a_ram_gap: assert property (@(posedge i_clk) disable iff (i_rst)
    i_ram_en |=> !i_ram_en)
    else $error("ram enable held for two cycles");

  // request fields frozen until the hub answers
  a_en_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_en && !i_done) |=> (i_en && $stable(i_rw) && $stable(i_addr)))
    else $error("debugger request changed before done");

endmodule

bind debug_mem_hub nes_debugger_asserts u_asserts (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_en     (mem.en),
  .i_rw     (mem.rw),
  .i_addr   (mem.addr),
  .i_done   (mem.done),
  .i_prg_en (i_prg_en),
  .i_ram_en (i_ram_en)
);

//--- testbench/tb_nes_debugger.sv
// ##############################
// nes debugger testbench with random spi commands
// and nes bus traffic checked against a model
// ##############################

module tb_nes_debugger;

  localparam int PRG_ADDR_W = 10;
  localparam int RAM_ADDR_W = 9;
  localparam int PRG_SIZE   = 1 << PRG_ADDR_W;
  localparam int RAM_SIZE   = 1 << RAM_ADDR_W;

  logic                  clk;
  logic                  rst;
  logic                  spi_clk;
  logic                  spi_cs_n;
  logic                  spi_copi;
  logic                  spi_cipo;
  logic                  nes_rst;
  logic                  prg_en;
  logic [PRG_ADDR_W-1:0] prg_addr;
  logic [7:0]            prg_data;
  logic                  ram_en;
  logic                  ram_rw;
  logic [RAM_ADDR_W-1:0] ram_addr;
  logic [7:0]            ram_wdata;
  logic [7:0]            ram_data;

  // reference model
  logic [7:0]  prg_model [0:PRG_SIZE-1];
  logic [7:0]  ram_model [0:RAM_SIZE-1];
  logic        cur_pool;
  logic [31:0] seed;
  logic [31:0] nes_seed;
  logic        nes_on;
  logic        nes_busy;

  nes_debugger_top #(
    .PRG_ADDR_W (PRG_ADDR_W),
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_nes_debugger_top (
    .i_clk_5mhz  (clk),
    .i_rst       (rst),
    .i_spi_clk   (spi_clk),
    .i_spi_cs_n  (spi_cs_n),
    .i_spi_copi  (spi_copi),
    .o_spi_cipo  (spi_cipo),
    .o_nes_rst   (nes_rst),
    .i_prg_en    (prg_en),
    .i_prg_addr  (prg_addr),
    .o_prg_data  (prg_data),
    .i_ram_en    (ram_en),
    .i_ram_rw    (ram_rw),
    .i_ram_addr  (ram_addr),
    .i_ram_wdata (ram_wdata),
    .o_ram_data  (ram_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected)
    begin
      $display("MISMATCH t=%0t %s: got %h expected %h", $time, msg, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
  endtask

  function automatic logic [7:0] model_read(input logic pool, input logic [15:0] addr);
    if (pool == nes_debugger_pkg::POOL_PRG)
      return prg_model[addr % PRG_SIZE];
    return ram_model[addr % RAM_SIZE];
  endfunction

  task automatic model_write(input logic pool, input logic [15:0] addr,
                             input logic [7:0] data);
    if (pool == nes_debugger_pkg::POOL_PRG)
      prg_model[addr % PRG_SIZE] = data;
    else
      ram_model[addr % RAM_SIZE] = data;
  endtask

  // one mode-0 byte with 8-clock half periods and a gap after it
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--)
    begin
      spi_copi <= tx[i];
      wait_clocks(8);
      rx[i] = spi_cipo;
      spi_clk <= 1'b1;
      wait_clocks(8);
      spi_clk <= 1'b0;
    end
    wait_clocks(32);
  endtask

  task automatic send(input logic [7:0] b);
    logic [7:0] dummy;
    spi_byte(b, dummy);
  endtask

  task automatic frame_begin();
    spi_cs_n <= 1'b0;
    wait_clocks(8);
  endtask

  task automatic frame_end();
    spi_cs_n <= 1'b1;
    wait_clocks(16);
  endtask

  // sends only the first sent of n data bytes when cut short
  task automatic write_mem(input logic [15:0] addr, input int n, input int sent);
    logic [7:0] data;
    int k;
    frame_begin();
    send(nes_debugger_pkg::CMD_WRITE_MEM);
    send(addr[15:8]);
    send(addr[7:0]);
    send(8'(n));
    for (k = 0; k < sent; k++)
    begin
      data = 8'(next_rand() >> 8);
      send(data);
      model_write(cur_pool, addr + 16'(k), data);
    end
    frame_end();
  endtask

  task automatic read_mem(input logic [15:0] addr, input int n, input int sent);
    logic [7:0] data;
    int k;
    frame_begin();
    send(nes_debugger_pkg::CMD_READ_MEM);
    send(addr[15:8]);
    send(addr[7:0]);
    send(8'(n));
    for (k = 0; k < sent; k++)
    begin
      spi_byte(8'h00, data);
      check(data, model_read(cur_pool, addr + 16'(k)), "debugger memory read");
    end
    frame_end();
  endtask

  task automatic write_value(input logic [7:0] id, input logic [15:0] v);
    frame_begin();
    send(nes_debugger_pkg::CMD_WRITE_VALUE);
    send(id);
    send(v[15:8]);
    send(v[7:0]);
    frame_end();
  endtask

  task automatic read_value(input logic [7:0] id, output logic [15:0] v);
    logic [7:0] hi;
    logic [7:0] lo;
    frame_begin();
    send(nes_debugger_pkg::CMD_READ_VALUE);
    send(id);
    spi_byte(8'h00, hi);
    spi_byte(8'h00, lo);
    frame_end();
    v = {hi, lo};
  endtask

  task automatic set_pool(input logic pool);
    write_value(nes_debugger_pkg::VALUE_MEM_POOL, {15'd0, pool});
    cur_pool = pool;
  endtask

  task automatic stop_nes();
    int t;
    nes_on = 1'b0;
    t = 0;
    while (nes_busy)
    begin
      @(posedge clk);
      t++;
      if (t > 100)
      begin
        $display("timeout: nes traffic did not stop");
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  // nes traffic on alternate cycles in the upper ram half
  initial
  begin
    logic [31:0]           r;
    logic                  do_prg;
    logic                  do_ram;
    logic                  ram_wr;
    logic [PRG_ADDR_W-1:0] pa;
    logic [RAM_ADDR_W-1:0] ra;
    nes_busy = 1'b0;
    forever
    begin
      @(posedge clk);
      if (nes_on)
      begin
        nes_busy = 1'b1;
        nes_seed = xorshift(nes_seed);
        r = nes_seed;
        pa = r[9:0];
        ra = {1'b1, r[17:10]};
        do_prg = r[20];
        do_ram = r[21];
        ram_wr = r[22];
        prg_en    <= do_prg;
        prg_addr  <= pa;
        ram_en    <= do_ram;
        ram_rw    <= ~ram_wr;
        ram_addr  <= ra;
        ram_wdata <= r[31:24];
        if (do_ram && ram_wr)
          ram_model[ra] = r[31:24];
        @(posedge clk);
        prg_en <= 1'b0;
        ram_en <= 1'b0;
        @(negedge clk);
        if (do_prg)
          check(prg_data, prg_model[pa], "nes prg read");
        if (do_ram && !ram_wr)
          check(ram_data, ram_model[ra], "nes ram read");
      end
      else
        nes_busy = 1'b0;
    end
  end

  initial
  begin
    logic [15:0] v;
    logic [15:0] addr;
    int          n;
    int          i;
    rst = 1'b1;
    spi_clk = 1'b0;
    spi_cs_n = 1'b1;
    spi_copi = 1'b0;
    prg_en = 1'b0;
    prg_addr = '0;
    ram_en = 1'b0;
    ram_rw = 1'b1;
    ram_addr = '0;
    ram_wdata = 8'h00;
    seed = 32'hb9ae;
    nes_seed = xorshift(32'hb9ae ^ 32'h5a5a0000);
    nes_on = 1'b0;
    cur_pool = nes_debugger_pkg::POOL_PRG;
    wait_clocks(2);
    rst <= 1'b0;
    wait_clocks(4);

    // reset values and the read-only id
    check(nes_rst, 1, "nes reset after reset");
    read_value(nes_debugger_pkg::VALUE_MEM_POOL, v);
    check(v, 0, "pool after reset");
    read_value(nes_debugger_pkg::VALUE_DEVICE_ID, v);
    check(v, nes_debugger_pkg::DEVICE_ID_CODE, "device id");
    write_value(nes_debugger_pkg::VALUE_DEVICE_ID, 16'h1234);
    read_value(nes_debugger_pkg::VALUE_DEVICE_ID, v);
    check(v, nes_debugger_pkg::DEVICE_ID_CODE, "device id after write");

    // load both pools completely
    set_pool(nes_debugger_pkg::POOL_PRG);
    for (i = 0; i < PRG_SIZE; i += 128)
      write_mem(16'(i), 128, 128);
    set_pool(nes_debugger_pkg::POOL_RAM);
    for (i = 0; i < RAM_SIZE; i += 128)
      write_mem(16'(i), 128, 128);

    // random bursts in both pools with wrap-around
    for (i = 0; i < 12; i++)
    begin
      set_pool(1'(next_rand() >> 31));
      addr = 16'(next_rand() >> 16);
      n = 1 + int'((next_rand() >> 8) % 24);
      write_mem(addr, n, n);
      read_mem(addr - 16'd2, n + 4, n + 4);
    end
    set_pool(nes_debugger_pkg::POOL_PRG);
    write_mem(16'hFFFD, 6, 6);
    read_mem(16'hFFFB, 10, 10);
    set_pool(nes_debugger_pkg::POOL_RAM);
    write_mem(16'h01FE, 5, 5);
    read_mem(16'h01FC, 9, 9);

    // debugger in the lower ram half while the nes runs
    nes_on = 1'b1;
    for (i = 0; i < 10; i++)
    begin
      v = 16'(next_rand() >> 16);
      addr = {v[15:9], 1'b0, 8'(v[7:0] % 8'hF0)};
      n = 1 + int'((next_rand() >> 8) % 16);
      write_mem(addr, n, n);
      read_mem(addr, n, n);
    end
    set_pool(nes_debugger_pkg::POOL_PRG);
    for (i = 0; i < 4; i++)
      read_mem(16'(next_rand() >> 16), 12, 12);
    stop_nes();
    set_pool(nes_debugger_pkg::POOL_RAM);
    read_mem(16'h0100, 128, 128);
    read_mem(16'h0180, 128, 128);

    // nes reset control and unknown ids
    write_value(nes_debugger_pkg::VALUE_NES_CTRL, 16'hFFFE);
    check(nes_rst, 0, "nes reset released");
    read_value(nes_debugger_pkg::VALUE_NES_CTRL, v);
    check(v, 0, "nes ctrl readback");
    write_value(nes_debugger_pkg::VALUE_NES_CTRL, 16'h0001);
    check(nes_rst, 1, "nes reset held");
    read_value(8'h37, v);
    check(v, 0, "unknown id");

    // bytes after an unknown command must not form a command
    frame_begin();
    send(8'h7A);
    send(nes_debugger_pkg::CMD_WRITE_VALUE);
    send(nes_debugger_pkg::VALUE_NES_CTRL);
    send(8'h00);
    send(8'h00);
    frame_end();
    check(nes_rst, 1, "nes reset after unknown command");

    // frames cut short
    write_mem(16'h0020, 6, 3);
    read_mem(16'h001E, 10, 10);
    read_mem(16'h0040, 8, 2);
    frame_begin();
    send(nes_debugger_pkg::CMD_READ_VALUE);
    send(nes_debugger_pkg::VALUE_DEVICE_ID);
    frame_end();
    frame_begin();
    send(nes_debugger_pkg::CMD_WRITE_VALUE);
    send(nes_debugger_pkg::VALUE_MEM_POOL);
    send(8'h00);
    frame_end();
    read_value(nes_debugger_pkg::VALUE_MEM_POOL, v);
    check(v, 1, "pool after cut write");
    read_mem(16'h0018, 24, 24);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verilog/debug_mem_hub.sv
// ##############################
// shares the prg and ram banks between the nes
// and the debugger, nes always wins a cycle
// ##############################

module debug_mem_hub #(
  parameter int PRG_ADDR_W = 10,
  parameter int RAM_ADDR_W = 9
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_pool,
  dbg_mem_if.target             mem,
  input  logic                  i_prg_en,
  input  logic [PRG_ADDR_W-1:0] i_prg_addr,
  output logic [7:0]            o_prg_data,
  input  logic                  i_ram_en,
  input  logic                  i_ram_rw,
  input  logic [RAM_ADDR_W-1:0] i_ram_addr,
  input  logic [7:0]            i_ram_wdata,
  output logic [7:0]            o_ram_data
);

  logic                  r_issued;
  logic                  r_ack;
  logic                  r_ack_pool;
  logic                  r_done;
  logic [7:0]            r_rdata;
  logic                  w_req;
  logic                  w_prg_grant;
  logic                  w_ram_grant;
  logic                  w_prg_we;
  logic [PRG_ADDR_W-1:0] w_prg_addr;
  logic [7:0]            w_prg_q;
  logic                  w_ram_we;
  logic [RAM_ADDR_W-1:0] w_ram_addr;
  logic [7:0]            w_ram_data;
  logic [7:0]            w_ram_q;

  // debugger only gets a bank in a cycle the nes leaves free
  assign w_req       = mem.en & ~r_issued;
  assign w_prg_grant = w_req & (i_pool == nes_debugger_pkg::POOL_PRG) & ~i_prg_en;
  assign w_ram_grant = w_req & (i_pool == nes_debugger_pkg::POOL_RAM) & ~i_ram_en;

  // prg is read-only on the nes side
  assign w_prg_we   = w_prg_grant & ~mem.rw;
  assign w_prg_addr = i_prg_en ? i_prg_addr : mem.addr[PRG_ADDR_W-1:0];

  assign w_ram_we   = i_ram_en ? ~i_ram_rw : ~mem.rw;
  assign w_ram_addr = i_ram_en ? i_ram_addr : mem.addr[RAM_ADDR_W-1:0];
  assign w_ram_data = i_ram_en ? i_ram_wdata : mem.wdata;

  memory_bank #(.ADDR_W(PRG_ADDR_W)) u_prg_bank (
    .i_clk  (i_clk),
    .i_en   (i_prg_en | w_prg_grant),
    .i_we   (w_prg_we),
    .i_addr (w_prg_addr),
    .i_data (mem.wdata),
    .o_data (w_prg_q)
  );

  memory_bank #(.ADDR_W(RAM_ADDR_W)) u_ram_bank (
    .i_clk  (i_clk),
    .i_en   (i_ram_en | w_ram_grant),
    .i_we   (w_ram_we),
    .i_addr (w_ram_addr),
    .i_data (w_ram_data),
    .o_data (w_ram_q)
  );

  // grant, then bank data, then done with the captured byte
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_issued <= 1'b0;
      r_ack    <= 1'b0;
      r_done   <= 1'b0;
    end
    else
    begin
      r_ack  <= w_prg_grant | w_ram_grant;
      r_done <= r_ack;
      if (w_prg_grant || w_ram_grant)
        r_issued <= 1'b1;
      else if (r_done)
        r_issued <= 1'b0;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (w_prg_grant || w_ram_grant)
      r_ack_pool <= i_pool;
    if (r_ack)
      r_rdata <= (r_ack_pool == nes_debugger_pkg::POOL_PRG) ? w_prg_q : w_ram_q;
  end

  assign mem.done   = r_done;
  assign mem.rdata  = r_rdata;
  assign o_prg_data = w_prg_q;
  assign o_ram_data = w_ram_q;

endmodule

//--- verilog/debugger_cmd.sv
// ##############################
// command parser, turns spi bytes into memory
// and value accesses and queues the reply bytes
// ##############################

module debugger_cmd (
  input  logic            i_clk,
  input  logic            i_rst,
  spi_byte_if.host        spi,
  dbg_mem_if.requester    mem,
  dbg_value_if.requester  value
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_ADDR_HI,
    S_ADDR_LO,
    S_COUNT,
    S_MEM_READ,
    S_MEM_WRITE,
    S_VALUE_ID,
    S_VALUE_FETCH,
    S_VALUE_RD_HI,
    S_VALUE_RD_LO,
    S_VALUE_WR_HI,
    S_VALUE_WR_LO,
    S_IGNORE
  } state_t;

  state_t                                  r_state;
  logic [7:0]                              r_cmd;
  logic [nes_debugger_pkg::DBG_ADDR_W-1:0] r_addr;
  logic [7:0]                              r_count;
  logic                                    r_mem_en;
  logic                                    r_mem_rw;
  logic [7:0]                              r_mem_wdata;
  logic                                    r_value_en;
  logic                                    r_value_wr;
  logic [7:0]                              r_value_id;
  logic [15:0]                             r_value_data;
  logic [7:0]                              r_tx_byte;
  logic                                    r_tx_dv;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_state    <= S_IDLE;
      r_mem_en   <= 1'b0;
      r_value_en <= 1'b0;
      r_tx_dv    <= 1'b0;
    end
    else
    begin
      r_tx_dv    <= 1'b0;
      r_value_en <= 1'b0;

      // a memory access always runs to done, even across a frame end
      if (mem.done)
      begin
        r_mem_en <= 1'b0;
        r_addr   <= r_addr + 1'b1;
        if (r_state == S_MEM_READ)
        begin
          r_tx_byte <= mem.rdata;
          r_tx_dv   <= 1'b1;
        end
      end

      if (!spi.frame)
        r_state <= S_IDLE;
      else if (r_state == S_VALUE_FETCH)
      begin
        r_value_data <= value.rdata;
        r_tx_byte    <= value.rdata[15:8];
        r_tx_dv      <= 1'b1;
        r_state      <= S_VALUE_RD_HI;
      end
      else if (spi.rx_dv)
      begin
        case (r_state)
          S_IDLE:
          begin
            r_cmd <= spi.rx_byte;
            case (spi.rx_byte)
              nes_debugger_pkg::CMD_READ_MEM,
              nes_debugger_pkg::CMD_WRITE_MEM:   r_state <= S_ADDR_HI;
              nes_debugger_pkg::CMD_READ_VALUE,
              nes_debugger_pkg::CMD_WRITE_VALUE: r_state <= S_VALUE_ID;
              default:                           r_state <= S_IGNORE;
            endcase
          end
          S_ADDR_HI:
          begin
            r_addr[15:8] <= spi.rx_byte;
            r_state      <= S_ADDR_LO;
          end
          S_ADDR_LO:
          begin
            r_addr[7:0] <= spi.rx_byte;
            r_state     <= S_COUNT;
          end
          S_COUNT:
          begin
            r_count <= spi.rx_byte;
            if (spi.rx_byte == 8'd0)
              r_state <= S_IDLE;
            else if (r_cmd == nes_debugger_pkg::CMD_READ_MEM)
            begin
              // first read goes out now so its byte is ready for dummy one
              r_mem_en <= 1'b1;
              r_mem_rw <= 1'b1;
              r_state  <= S_MEM_READ;
            end
            else
              r_state <= S_MEM_WRITE;
          end
          S_MEM_READ:
          begin
            r_count <= r_count - 8'd1;
            if (r_count == 8'd1)
              r_state <= S_IDLE;
            else
            begin
              r_mem_en <= 1'b1;
              r_mem_rw <= 1'b1;
            end
          end
          S_MEM_WRITE:
          begin
            r_mem_en    <= 1'b1;
            r_mem_rw    <= 1'b0;
            r_mem_wdata <= spi.rx_byte;
            r_count     <= r_count - 8'd1;
            if (r_count == 8'd1)
              r_state <= S_IDLE;
          end
          S_VALUE_ID:
          begin
            r_value_id <= spi.rx_byte;
            if (r_cmd == nes_debugger_pkg::CMD_READ_VALUE)
            begin
              r_value_en <= 1'b1;
              r_value_wr <= 1'b0;
              r_state    <= S_VALUE_FETCH;
            end
            else
              r_state <= S_VALUE_WR_HI;
          end
          S_VALUE_RD_HI:
          begin
            r_tx_byte <= r_value_data[7:0];
            r_tx_dv   <= 1'b1;
            r_state   <= S_VALUE_RD_LO;
          end
          S_VALUE_RD_LO: r_state <= S_IDLE;
          S_VALUE_WR_HI:
          begin
            r_value_data[15:8] <= spi.rx_byte;
            r_state            <= S_VALUE_WR_LO;
          end
          S_VALUE_WR_LO:
          begin
            r_value_data[7:0] <= spi.rx_byte;
            r_value_en        <= 1'b1;
            r_value_wr        <= 1'b1;
            r_state           <= S_IDLE;
          end
          // unknown command, drop bytes until chip select rises
          default: r_state <= S_IGNORE;
        endcase
      end
    end
  end

  assign mem.en      = r_mem_en;
  assign mem.rw      = r_mem_rw;
  assign mem.addr    = r_addr;
  assign mem.wdata   = r_mem_wdata;
  assign value.en    = r_value_en;
  assign value.wr    = r_value_wr;
  assign value.id    = r_value_id;
  assign value.wdata = r_value_data;
  assign spi.tx_byte = r_tx_byte;
  assign spi.tx_dv   = r_tx_dv;

endmodule

//--- verilog/debugger_if.sv
// ##############################
// internal buses of the debugger
// spi bytes, memory requests and value accesses
// ##############################

interface spi_byte_if;
  logic [7:0] rx_byte;
  logic       rx_dv;
  logic       frame;
  logic [7:0] tx_byte;
  logic       tx_dv;

  modport peripheral (output rx_byte, output rx_dv, output frame,
                      input tx_byte, input tx_dv);
  modport host (input rx_byte, input rx_dv, input frame,
                output tx_byte, output tx_dv);
endinterface

interface dbg_mem_if;
  // en held until done, rw high for a read
  logic                                en;
  logic                                rw;
  logic [nes_debugger_pkg::DBG_ADDR_W-1:0] addr;
  logic [7:0]                          wdata;
  logic [7:0]                          rdata;
  logic                                done;

  modport requester (output en, output rw, output addr, output wdata,
                     input rdata, input done);
  modport target (input en, input rw, input addr, input wdata,
                  output rdata, output done);
endinterface

interface dbg_value_if;
  logic        en;
  logic        wr;
  logic [7:0]  id;
  logic [15:0] wdata;
  logic [15:0] rdata;

  modport requester (output en, output wr, output id, output wdata, input rdata);
  modport target (input en, input wr, input id, input wdata, output rdata);
endinterface

//--- verilog/debugger_values.sv
// ##############################
// debugger control values
// nes reset and pool select, plus the device id
// ##############################

module debugger_values (
  input  logic         i_clk,
  input  logic         i_rst,
  dbg_value_if.target  value,
  output logic         o_nes_rst,
  output logic         o_pool
);

  logic r_nes_rst;
  logic r_pool;

  // nes held in reset until the host lets it go
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_nes_rst <= 1'b1;
      r_pool    <= nes_debugger_pkg::POOL_PRG;
    end
    else if (value.en && value.wr)
    begin
      case (value.id)
        nes_debugger_pkg::VALUE_NES_CTRL: r_nes_rst <= value.wdata[0];
        nes_debugger_pkg::VALUE_MEM_POOL: r_pool    <= value.wdata[0];
        default: ;
      endcase
    end
  end

  always_comb
  begin
    case (value.id)
      nes_debugger_pkg::VALUE_NES_CTRL:  value.rdata = {15'd0, r_nes_rst};
      nes_debugger_pkg::VALUE_MEM_POOL:  value.rdata = {15'd0, r_pool};
      nes_debugger_pkg::VALUE_DEVICE_ID: value.rdata = nes_debugger_pkg::DEVICE_ID_CODE;
      default:                           value.rdata = 16'd0;
    endcase
  end

  assign o_nes_rst = r_nes_rst;
  assign o_pool    = r_pool;

endmodule

//--- verilog/memory_bank.sv
// ##############################
// single-port byte ram, registered read
// ##############################

module memory_bank #(
  parameter int ADDR_W = 10
) (
  input  logic              i_clk,
  input  logic              i_en,
  input  logic              i_we,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [7:0]        i_data,
  output logic [7:0]        o_data
);

  logic [7:0] r_mem [0:(1<<ADDR_W)-1];

  // o_data only moves on a read
  always_ff @(posedge i_clk)
  begin
    if (i_en)
    begin
      if (i_we)
        r_mem[i_addr] <= i_data;
      else
        o_data <= r_mem[i_addr];
    end
  end

endmodule

//--- verilog/nes_debugger_pkg.sv
// ##############################
// shared codes and widths for the nes debugger
// used by the rtl and the testbench through scoped names
// ##############################

package nes_debugger_pkg;

  // debugger address width as seen over spi
  localparam int DBG_ADDR_W = 16;

  // command bytes, first byte of every frame
  localparam logic [7:0] CMD_READ_MEM    = 8'h02;
  localparam logic [7:0] CMD_WRITE_MEM   = 8'h03;
  localparam logic [7:0] CMD_READ_VALUE  = 8'h04;
  localparam logic [7:0] CMD_WRITE_VALUE = 8'h05;

  // value ids
  localparam logic [7:0] VALUE_NES_CTRL  = 8'd0;
  localparam logic [7:0] VALUE_MEM_POOL  = 8'd1;
  localparam logic [7:0] VALUE_DEVICE_ID = 8'd2;

  // read-only identity, "NE" in ascii
  localparam logic [15:0] DEVICE_ID_CODE = 16'h4E45;

  // memory pool codes
  localparam logic POOL_PRG = 1'b0;
  localparam logic POOL_RAM = 1'b1;

endpackage

//--- verilog/nes_debugger_top.sv
// ##############################
// nes debugger top, spi host port plus
// the nes prg and ram buses
// ##############################

module nes_debugger_top #(
  parameter int PRG_ADDR_W = 10,
  parameter int RAM_ADDR_W = 9
) (
  input  logic                  i_clk_5mhz,
  input  logic                  i_rst,

  // spi host link
  input  logic                  i_spi_clk,
  input  logic                  i_spi_cs_n,
  input  logic                  i_spi_copi,
  output logic                  o_spi_cipo,

  output logic                  o_nes_rst,

  // nes prg bus, read only
  input  logic                  i_prg_en,
  input  logic [PRG_ADDR_W-1:0] i_prg_addr,
  output logic [7:0]            o_prg_data,

  // nes work ram bus
  input  logic                  i_ram_en,
  input  logic                  i_ram_rw,
  input  logic [RAM_ADDR_W-1:0] i_ram_addr,
  input  logic [7:0]            i_ram_wdata,
  output logic [7:0]            o_ram_data
);

  spi_byte_if  spi_bus ();
  dbg_mem_if   mem_bus ();
  dbg_value_if value_bus ();

  logic w_pool;

  spi_peripheral u_spi (
    .i_clk      (i_clk_5mhz),
    .i_rst      (i_rst),
    .i_spi_clk  (i_spi_clk),
    .i_spi_cs_n (i_spi_cs_n),
    .i_spi_copi (i_spi_copi),
    .o_spi_cipo (o_spi_cipo),
    .spi        (spi_bus)
  );

  debugger_cmd u_cmd (
    .i_clk (i_clk_5mhz),
    .i_rst (i_rst),
    .spi   (spi_bus),
    .mem   (mem_bus),
    .value (value_bus)
  );

  debugger_values u_values (
    .i_clk     (i_clk_5mhz),
    .i_rst     (i_rst),
    .value     (value_bus),
    .o_nes_rst (o_nes_rst),
    .o_pool    (w_pool)
  );

  debug_mem_hub #(
    .PRG_ADDR_W (PRG_ADDR_W),
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_mem_hub (
    .i_clk       (i_clk_5mhz),
    .i_rst       (i_rst),
    .i_pool      (w_pool),
    .mem         (mem_bus),
    .i_prg_en    (i_prg_en),
    .i_prg_addr  (i_prg_addr),
    .o_prg_data  (o_prg_data),
    .i_ram_en    (i_ram_en),
    .i_ram_rw    (i_ram_rw),
    .i_ram_addr  (i_ram_addr),
    .i_ram_wdata (i_ram_wdata),
    .o_ram_data  (o_ram_data)
  );

endmodule

//--- verilog/spi_peripheral.sv
// ##############################
// spi mode-0 peripheral, one byte at a time
// all pins sampled on the system clock
// ##############################

module spi_peripheral (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_spi_clk,
  input  logic           i_spi_cs_n,
  input  logic           i_spi_copi,
  output logic           o_spi_cipo,
  spi_byte_if.peripheral spi
);

  logic [1:0] r_clk_sync;
  logic [1:0] r_cs_sync;
  logic [1:0] r_copi_sync;
  logic       r_clk_prev;
  logic       w_rise;
  logic       w_fall;
  logic       w_active;
  logic [2:0] r_bit_cnt;
  logic [6:0] r_rx_shift;
  logic [7:0] r_rx_byte;
  logic       r_rx_dv;
  logic [7:0] r_tx_shift;
  logic [7:0] r_tx_next;

  // two-flop synchronisers plus one more stage on sclk for edges
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_clk_sync <= 2'b00;
      r_cs_sync  <= 2'b11;
      r_clk_prev <= 1'b0;
    end
    else
    begin
      r_clk_sync <= {r_clk_sync[0], i_spi_clk};
      r_cs_sync  <= {r_cs_sync[0], i_spi_cs_n};
      r_clk_prev <= r_clk_sync[1];
    end
  end

  always_ff @(posedge i_clk)
  begin
    r_copi_sync <= {r_copi_sync[0], i_spi_copi};
  end

  assign w_rise   = r_clk_sync[1] & ~r_clk_prev;
  assign w_fall   = ~r_clk_sync[1] & r_clk_prev;
  assign w_active = ~r_cs_sync[1];

  // receive, msb first on rising edges
  always_ff @(posedge i_clk)
  begin
    if (i_rst || !w_active)
    begin
      r_bit_cnt <= 3'd0;
      r_rx_dv   <= 1'b0;
    end
    else
    begin
      r_rx_dv <= 1'b0;
      if (w_rise)
      begin
        r_rx_shift <= {r_rx_shift[5:0], r_copi_sync[1]};
        r_bit_cnt  <= r_bit_cnt + 3'd1;
        if (r_bit_cnt == 3'd7)
        begin
          r_rx_byte <= {r_rx_shift, r_copi_sync[1]};
          r_rx_dv   <= 1'b1;
        end
      end
    end
  end

  // transmit buffer is consumed by the first rising edge of a byte
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_tx_next  <= 8'h00;
      r_tx_shift <= 8'h00;
    end
    else
    begin
      if (spi.tx_dv)
        r_tx_next <= spi.tx_byte;
      else if (!w_active || (w_rise && r_bit_cnt == 3'd0))
        r_tx_next <= 8'h00;

      // between bytes the msb of the next reply sits on cipo
      if (r_bit_cnt == 3'd0 && !w_rise)
        r_tx_shift <= r_tx_next;
      else if (w_fall && w_active)
        r_tx_shift <= {r_tx_shift[6:0], 1'b0};
    end
  end

  assign o_spi_cipo  = r_tx_shift[7];
  assign spi.rx_byte = r_rx_byte;
  assign spi.rx_dv   = r_rx_dv;
  assign spi.frame   = w_active;

endmodule
